//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbLedCtrl
FILELIST  = files.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

//--- axiLiteSlave.sv
// AXI4-Lite slave bridge, single beats only, write strobes ignored
// One write and one read may be in flight at the same time
`timescale 1ns/1ps

module axiLiteSlave
(
	input  logic            iSysClk,
	input  logic            reset,
	// Write address and data
	input  ledPkg::axiAddrT awAddr,
	input  logic            awValid,
	output logic            awReady,
	input  ledPkg::axiDataT wData,
	input  logic            wValid,
	output logic            wReady,
	// Write response
	output ledPkg::axiRespT bResp,
	output logic            bValid,
	input  logic            bReady,
	// Read address
	input  ledPkg::axiAddrT arAddr,
	input  logic            arValid,
	output logic            arReady,
	// Read data
	output ledPkg::axiDataT rData,
	output ledPkg::axiRespT rResp,
	output logic            rValid,
	input  logic            rReady,
	// Register access side
	output logic            wrEn,
	output ledPkg::axiAddrT wrAddr,
	output ledPkg::axiDataT wrData,
	input  logic            wrErr,
	output logic            rdEn,
	output ledPkg::axiAddrT rdAddr,
	input  ledPkg::axiDataT rdData,
	input  logic            rdErr,
	input  logic            rdValid
);

	typedef enum logic [2:0]
	{
		WrIdle,
		WrResp,
		RdIdle,
		RdWait,
		RdResp
	} busStateE;

	busStateE wrState;
	busStateE rdState;
	logic     wrHs;
	logic     rdHs;

	//--------------------------------------------------------------------
	// Write path
	//--------------------------------------------------------------------
	// Address and data are taken together, never one without the other
	assign wrHs    = awValid && wValid && (wrState == WrIdle);
	assign awReady = wrHs;
	assign wReady  = wrHs;
	assign wrEn    = wrHs;
	assign wrAddr  = awAddr;
	assign wrData  = wData;
	assign bValid  = (wrState == WrResp);

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			wrState <= WrIdle;
		else if (wrState == WrIdle && wrHs)
			wrState <= WrResp;
		else if (wrState == WrResp && bReady)
			wrState <= WrIdle;
	end

	always_ff @(posedge iSysClk)
	begin
		if (wrHs)
			bResp <= wrErr ? ledPkg::RespSlvErr : ledPkg::RespOkay;
	end

	//--------------------------------------------------------------------
	// Read path
	//--------------------------------------------------------------------
	assign rdHs    = arValid && (rdState == RdIdle);
	assign arReady = rdHs;
	assign rdEn    = rdHs;
	assign rdAddr  = arAddr;
	assign rValid  = (rdState == RdResp);

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			rdState <= RdIdle;
		else
		begin
			case (rdState)
				RdIdle:  if (rdHs) rdState <= RdWait;
				RdWait:  if (rdValid) rdState <= RdResp;		// Register block answers next cycle
				RdResp:  if (rReady) rdState <= RdIdle;
				default: rdState <= RdIdle;
			endcase
		end
	end

	// Response held here until the master takes it
	always_ff @(posedge iSysClk)
	begin
		if (rdState == RdWait && rdValid)
		begin
			rData <= rdData;
			rResp <= rdErr ? ledPkg::RespSlvErr : ledPkg::RespOkay;
		end
	end

	// Read response must not move while the master stalls
	assert property (@(posedge iSysClk) disable iff (reset)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp));

	assert property (@(posedge iSysClk) disable iff (reset)
		$rose(bValid) |-> $past(awValid && awReady && wValid && wReady));

endmodule

//--- files.f
ledPkg.sv
axiLiteSlave.sv
ledCsr.sv
ledChannel.sv
ledCtrlTop.sv
tbLedCtrl.sv

//--- ledChannel.sv
// One LED engine with free running PWM and an interval timer for blinking
// Full-on PWM is not reachable, the highest duty leaves one low cycle
`timescale 1ns/1ps

module ledChannel
#(
	parameter int pPwmWidth   = 16,
	parameter int pTimerWidth = 16
)
(
	input  logic                   iSysClk,
	input  logic                   reset,
	input  logic                   enable,
	input  ledPkg::ledModeE        flashMode,
	input  logic [pPwmWidth-1:0]   duty,
	input  logic [pTimerWidth-1:0] divisor,
	output logic                   led
);

	logic [pPwmWidth-1:0]   pwmCnt;
	logic [pTimerWidth-1:0] timerCnt;
	logic                   phase;
	logic                   pwmLevel;
	logic                   ledNext;

	//--------------------------------------------------------------------
	// PWM
	//--------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			pwmCnt <= '0;
		else
			pwmCnt <= pwmCnt + 1'b1;		// Wraps every 2^pPwmWidth cycles
	end

	assign pwmLevel = (pwmCnt < duty);

	//--------------------------------------------------------------------
	// Interval timer and blink phase
	//--------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			timerCnt <= '0;
			phase    <= 1'b0;
		end
		else if (!enable)
		begin
			timerCnt <= divisor;		// Restart cleanly on the next enable
			phase    <= 1'b0;
		end
		else if (timerCnt == '0)
		begin
			timerCnt <= divisor;		// New divisor only lands here
			phase    <= ~phase;
		end
		else
			timerCnt <= timerCnt - 1'b1;
	end

	//--------------------------------------------------------------------
	// Output select
	//--------------------------------------------------------------------
	always_comb
	begin
		case (flashMode)
			ledPkg::ModeSteady:   ledNext = 1'b1;
			ledPkg::ModeBlink:    ledNext = phase;
			ledPkg::ModePwm:      ledNext = pwmLevel;
			ledPkg::ModePwmBlink: ledNext = pwmLevel & phase;
			default:              ledNext = 1'b0;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			led <= 1'b0;
		else
			led <= enable & ledNext;
	end

endmodule

//--- ledCsr.sv
// LED control and status registers, word aligned offsets only
// Foreign block numbers and unmapped offsets flag an error and read as zero
`timescale 1ns/1ps

module ledCsr
#(
	parameter logic [7:0] pBlockId    = 8'h01,
	parameter int         pLedCount   = 5,
	parameter int         pPwmWidth   = 16,
	parameter int         pTimerWidth = 16
)
(
	input  logic                               iSysClk,
	input  logic                               reset,
	// Single cycle write access
	input  logic                               wrEn,
	input  ledPkg::axiAddrT                    wrAddr,
	input  ledPkg::axiDataT                    wrData,
	output logic                               wrErr,
	// Single cycle read access, answered one cycle later
	input  logic                               rdEn,
	input  ledPkg::axiAddrT                    rdAddr,
	output ledPkg::axiDataT                    rdData,
	output logic                               rdErr,
	output logic                               rdValid,
	// Settings for the channels
	output logic [pLedCount-1:0]               ledEn,
	output ledPkg::ledModeE                    flashMode,
	output logic [pLedCount*pPwmWidth-1:0]     dutyAll,
	output logic [pLedCount*pTimerWidth-1:0]   timerAll
);

	// Enable, mode, then one duty and one divisor per LED
	localparam int RegWords = 2 + 2 * pLedCount;

	ledPkg::regOffsetT wrOff;
	ledPkg::regOffsetT rdOff;
	logic [5:0]        wrWord;
	logic [5:0]        rdWord;
	logic              wrHit;
	logic              rdHit;
	ledPkg::axiDataT   rdMux;

	function automatic logic addrHit(input ledPkg::axiAddrT addr);
		addrHit = (addr[15:8] == pBlockId) && (addr[1:0] == 2'b00)
			&& (addr[7:2] < RegWords);
	endfunction

	assign wrOff  = wrAddr[7:0];
	assign rdOff  = rdAddr[7:0];
	assign wrWord = wrOff[7:2];
	assign rdWord = rdOff[7:2];
	assign wrHit  = addrHit(wrAddr);
	assign rdHit  = addrHit(rdAddr);
	assign wrErr  = !wrHit;		// Only sampled by the bridge with wrEn

	//--------------------------------------------------------------------
	// Register update
	//--------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			ledEn     <= '0;
			flashMode <= ledPkg::ModeSteady;
			dutyAll   <= '0;
			timerAll  <= '1;		// Slowest blink out of reset
		end
		else if (wrEn && wrHit)
		begin
			if (wrWord == 6'd0)
				ledEn <= wrData[pLedCount-1:0];
			if (wrWord == 6'd1)
				flashMode <= ledPkg::ledModeE'(wrData[1:0]);
			for (int i = 0; i < pLedCount; i++)
			begin
				if (wrWord == 6'(2 + i))
					dutyAll[i*pPwmWidth +: pPwmWidth] <= wrData[pPwmWidth-1:0];
				if (wrWord == 6'(2 + pLedCount + i))
					timerAll[i*pTimerWidth +: pTimerWidth] <= wrData[pTimerWidth-1:0];
			end
		end
	end

	//--------------------------------------------------------------------
	// Read multiplexer
	//--------------------------------------------------------------------
	always_comb
	begin
		rdMux = '0;		// Unused upper bits stay zero
		if (rdWord == 6'd0)
			rdMux[pLedCount-1:0] = ledEn;
		if (rdWord == 6'd1)
			rdMux[1:0] = flashMode;
		for (int i = 0; i < pLedCount; i++)
		begin
			if (rdWord == 6'(2 + i))
				rdMux[pPwmWidth-1:0] = dutyAll[i*pPwmWidth +: pPwmWidth];
			if (rdWord == 6'(2 + pLedCount + i))
				rdMux[pTimerWidth-1:0] = timerAll[i*pTimerWidth +: pTimerWidth];
		end
		if (!rdHit)
			rdMux = '0;
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			rdValid <= 1'b0;
		else
			rdValid <= rdEn;
	end

	always_ff @(posedge iSysClk)
	begin
		if (rdEn)
		begin
			rdData <= rdMux;
			rdErr  <= !rdHit;
		end
	end

	assert property (@(posedge iSysClk) disable iff (reset)
		rdValid == $past(rdEn));

endmodule

//--- ledCtrlTop.sv
// LED controller on AXI4-Lite, one register block and pLedCount channels
// pLedCount 1 to 8, PWM and timer widths 4 to 16
`timescale 1ns/1ps

module ledCtrlTop
#(
	parameter logic [7:0] pBlockId    = 8'h01,
	parameter int         pLedCount   = 5,
	parameter int         pPwmWidth   = 16,
	parameter int         pTimerWidth = 16
)
(
	input  logic                 iSysClk,
	input  logic                 reset,
	input  ledPkg::axiAddrT      awAddr,
	input  logic                 awValid,
	output logic                 awReady,
	input  ledPkg::axiDataT      wData,
	input  logic                 wValid,
	output logic                 wReady,
	output ledPkg::axiRespT      bResp,
	output logic                 bValid,
	input  logic                 bReady,
	input  ledPkg::axiAddrT      arAddr,
	input  logic                 arValid,
	output logic                 arReady,
	output ledPkg::axiDataT      rData,
	output ledPkg::axiRespT      rResp,
	output logic                 rValid,
	input  logic                 rReady,
	output logic [pLedCount-1:0] ledOut
);

	logic                               wrEn;
	ledPkg::axiAddrT                    wrAddr;
	ledPkg::axiDataT                    wrData;
	logic                               wrErr;
	logic                               rdEn;
	ledPkg::axiAddrT                    rdAddr;
	ledPkg::axiDataT                    rdData;
	logic                               rdErr;
	logic                               rdValid;
	logic [pLedCount-1:0]               ledEn;
	ledPkg::ledModeE                    flashMode;
	logic [pLedCount*pPwmWidth-1:0]     dutyAll;
	logic [pLedCount*pTimerWidth-1:0]   timerAll;

	axiLiteSlave bridge_i
	(
		.iSysClk (iSysClk), .reset   (reset),
		.awAddr  (awAddr),  .awValid (awValid), .awReady (awReady),
		.wData   (wData),   .wValid  (wValid),  .wReady  (wReady),
		.bResp   (bResp),   .bValid  (bValid),  .bReady  (bReady),
		.arAddr  (arAddr),  .arValid (arValid), .arReady (arReady),
		.rData   (rData),   .rResp   (rResp),   .rValid  (rValid),  .rReady (rReady),
		.wrEn    (wrEn),    .wrAddr  (wrAddr),  .wrData  (wrData),  .wrErr  (wrErr),
		.rdEn    (rdEn),    .rdAddr  (rdAddr),  .rdData  (rdData),
		.rdErr   (rdErr),   .rdValid (rdValid)
	);

	ledCsr #(
		.pBlockId    (pBlockId),
		.pLedCount   (pLedCount),
		.pPwmWidth   (pPwmWidth),
		.pTimerWidth (pTimerWidth)
	) csr_i
	(
		.iSysClk (iSysClk), .reset   (reset),
		.wrEn    (wrEn),    .wrAddr  (wrAddr),  .wrData (wrData), .wrErr (wrErr),
		.rdEn    (rdEn),    .rdAddr  (rdAddr),  .rdData (rdData),
		.rdErr   (rdErr),   .rdValid (rdValid),
		.ledEn   (ledEn),   .flashMode (flashMode),
		.dutyAll (dutyAll), .timerAll  (timerAll)
	);

	// One engine per LED, each on its own slice of the flat settings
	for (genvar i = 0; i < pLedCount; i++)
	begin : genChannel
		ledChannel #(
			.pPwmWidth   (pPwmWidth),
			.pTimerWidth (pTimerWidth)
		) channel_i
		(
			.iSysClk   (iSysClk),
			.reset     (reset),
			.enable    (ledEn[i]),
			.flashMode (flashMode),
			.duty      (dutyAll[i*pPwmWidth +: pPwmWidth]),
			.divisor   (timerAll[i*pTimerWidth +: pTimerWidth]),
			.led       (ledOut[i])
		);
	end

endmodule

//--- ledPkg.sv
// Shared bus widths, response codes and the LED flash modes
// Address bits 15..8 select the block and bits 7..0 the register offset
package ledPkg;

	//--------------------------------------------------------------------
	// Bus types
	//--------------------------------------------------------------------
	typedef logic [15:0] axiAddrT;		// Byte address on the bus
	typedef logic [31:0] axiDataT;		// One bus data word
	typedef logic [1:0]  axiRespT;		// AXI response code
	typedef logic [7:0]  regOffsetT;	// Register offset inside one block

	localparam axiRespT RespOkay   = 2'b00;
	localparam axiRespT RespSlvErr = 2'b10;

	//--------------------------------------------------------------------
	// Flash mode, one setting shared by every LED
	//--------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		ModeSteady   = 2'd0,	// Constantly on
		ModeBlink    = 2'd1,	// Follows the blink phase
		ModePwm      = 2'd2,	// Follows the PWM level
		ModePwmBlink = 2'd3		// PWM gated by the blink phase
	} ledModeE;

endpackage

//--- tbLedCtrl.sv
// Testbench for the LED controller with five LEDs, 6-bit PWM and 8-bit interval timers
// Bus accesses run one at a time, except in the two back-pressure tests
`timescale 1ns/1ps

module tbLedCtrl;

	localparam logic [7:0] BlockId       = 8'h01;
	localparam int         LedCount      = 5;
	localparam int         PwmWidth      = 6;
	localparam int         TimerWidth    = 8;
	localparam int         PwmPeriod     = 1 << PwmWidth;
	localparam int         RegWords      = 2 + 2 * LedCount;
	localparam int         TimeoutCycles = 20000;	// About 90 accesses and short LED windows need < 3000

	logic                iSysClk;
	logic                reset;
	ledPkg::axiAddrT     awAddr;
	logic                awValid;
	logic                awReady;
	ledPkg::axiDataT     wData;
	logic                wValid;
	logic                wReady;
	ledPkg::axiRespT     bResp;
	logic                bValid;
	logic                bReady;
	ledPkg::axiAddrT     arAddr;
	logic                arValid;
	logic                arReady;
	ledPkg::axiDataT     rData;
	ledPkg::axiRespT     rResp;
	logic                rValid;
	logic                rReady;
	logic [LedCount-1:0] ledOut;

	int seed   = 32'h56df;
	int cycles = 0;

	// Shadow of the register map and the responses still expected
	logic [LedCount-1:0]   shEn;
	logic [1:0]            shMode;
	logic [PwmWidth-1:0]   shDuty [LedCount];
	logic [TimerWidth-1:0] shDiv  [LedCount];
	ledPkg::axiDataT       rdExpData [$];
	ledPkg::axiRespT       rdExpResp [$];
	ledPkg::axiRespT       wrExpResp [$];

	ledCtrlTop #(
		.pBlockId    (BlockId),
		.pLedCount   (LedCount),
		.pPwmWidth   (PwmWidth),
		.pTimerWidth (TimerWidth)
	) dut_i
	(
		.iSysClk (iSysClk), .reset   (reset),
		.awAddr  (awAddr),  .awValid (awValid), .awReady (awReady),
		.wData   (wData),   .wValid  (wValid),  .wReady  (wReady),
		.bResp   (bResp),   .bValid  (bValid),  .bReady  (bReady),
		.arAddr  (arAddr),  .arValid (arValid), .arReady (arReady),
		.rData   (rData),   .rResp   (rResp),   .rValid  (rValid),  .rReady (rReady),
		.ledOut  (ledOut)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #4 iSysClk = ~iSysClk;
	end

	always @(posedge iSysClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles)
		begin
			$display("timeout, the tests did not finish within %0d cycles", TimeoutCycles);
			stopRun();
		end
	end

	//--------------------------------------------------------------------
	// Reference model
	//--------------------------------------------------------------------
	function automatic ledPkg::axiAddrT addrOf(input int word);
		addrOf = {BlockId, 8'(word * 4)};
	endfunction

	function automatic void expectRead(input ledPkg::axiAddrT addr,
		output ledPkg::axiDataT data, output ledPkg::axiRespT resp);
		int word;
		word = int'(addr[7:2]);
		data = '0;
		if (addr[15:8] != BlockId || addr[1:0] != 2'b00 || word >= RegWords)
			resp = ledPkg::RespSlvErr;		// Foreign block, misaligned or unmapped
		else
		begin
			resp = ledPkg::RespOkay;
			if (word == 0)
				data[LedCount-1:0] = shEn;
			else if (word == 1)
				data[1:0] = shMode;
			else if (word < 2 + LedCount)
				data[PwmWidth-1:0] = shDuty[word-2];
			else
				data[TimerWidth-1:0] = shDiv[word-2-LedCount];
		end
	endfunction

	function automatic logic expectLed(input ledPkg::ledModeE mode, input int pwmCnt,
		input int duty, input logic phase, input logic enable);
		logic level;
		level = (pwmCnt < duty);
		if (!enable)
			expectLed = 1'b0;
		else if (mode == ledPkg::ModeSteady)
			expectLed = 1'b1;
		else if (mode == ledPkg::ModeBlink)
			expectLed = phase;
		else if (mode == ledPkg::ModePwm)
			expectLed = level;
		else
			expectLed = level & phase;
	endfunction

	// High cycles in one full PWM period
	function automatic int expectHighs(input ledPkg::ledModeE mode, input int duty,
		input logic phase);
		int n;
		n = 0;
		for (int c = 0; c < PwmPeriod; c++)
			if (expectLed(mode, c, duty, phase, 1'b1))
				n++;
		expectHighs = n;
	endfunction

	task automatic shadowWrite(input ledPkg::axiAddrT addr, input ledPkg::axiDataT data);
		int word;
		word = int'(addr[7:2]);
		if (word == 0)
			shEn = data[LedCount-1:0];
		else if (word == 1)
			shMode = data[1:0];
		else if (word < 2 + LedCount)
			shDuty[word-2] = data[PwmWidth-1:0];
		else
			shDiv[word-2-LedCount] = data[TimerWidth-1:0];
	endtask

	task automatic pushRead(input ledPkg::axiAddrT addr);
		ledPkg::axiDataT data;
		ledPkg::axiRespT resp;
		expectRead(addr, data, resp);
		rdExpData.push_back(data);
		rdExpResp.push_back(resp);
	endtask

	task automatic pushWrite(input ledPkg::axiAddrT addr, input ledPkg::axiDataT data);
		ledPkg::axiDataT oldData;
		ledPkg::axiRespT resp;
		expectRead(addr, oldData, resp);
		wrExpResp.push_back(resp);
		if (resp == ledPkg::RespOkay)
			shadowWrite(addr, data);
	endtask

	//--------------------------------------------------------------------
	// Compare tasks and the response monitor
	//--------------------------------------------------------------------
	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkData(input string name, input ledPkg::axiDataT got,
		input ledPkg::axiDataT exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkResp(input string name, input ledPkg::axiRespT got,
		input ledPkg::axiRespT exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkLed(input int idx, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch ledOut[%0d]: got 0x%0h, expected 0x%0h", idx, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stopRun();
		end
	endtask

	// Transfers happen on the next rising edge, so mid-cycle values are final
	always @(negedge iSysClk)
	begin
		if (rValid && rReady)
		begin
			if (rdExpData.size() == 0)
			begin
				$display("read data arrived while no read was outstanding");
				stopRun();
			end
			else
			begin
				checkData("rData", rData, rdExpData.pop_front());
				checkResp("rResp", rResp, rdExpResp.pop_front());
			end
		end
		if (bValid && bReady)
		begin
			if (wrExpResp.size() == 0)
			begin
				$display("write response arrived while no write was outstanding");
				stopRun();
			end
			else
				checkResp("bResp", bResp, wrExpResp.pop_front());
		end
	end

	//--------------------------------------------------------------------
	// Bus driver
	//--------------------------------------------------------------------
	task automatic alignToEdge();
		@(posedge iSysClk);
		#1;
	endtask

	task automatic axiWrite(input ledPkg::axiAddrT addr, input ledPkg::axiDataT data);
		int stall;
		stall = $unsigned($random(seed)) % 4;
		pushWrite(addr, data);
		awAddr  = addr;
		wData   = data;
		awValid = 1'b1;
		wValid  = 1'b1;
		@(negedge iSysClk);
		while (!awReady)
			@(negedge iSysClk);
		checkFlag("wReady", wReady, 1'b1);
		alignToEdge();
		awValid = 1'b0;
		wValid  = 1'b0;
		bReady  = (stall == 0);		// Zero stall takes the response on its first cycle
		@(negedge iSysClk);
		checkFlag("bValid", bValid, 1'b1);		// One cycle after the handshake
		if (stall > 0)
		begin
			repeat (stall - 1)
				@(posedge iSysClk);
			alignToEdge();
			bReady = 1'b1;
		end
		alignToEdge();
		bReady = 1'b0;
	endtask

	task automatic axiRead(input ledPkg::axiAddrT addr);
		int stall;
		stall = $unsigned($random(seed)) % 4;
		pushRead(addr);
		arAddr  = addr;
		arValid = 1'b1;
		@(negedge iSysClk);
		while (!arReady)
			@(negedge iSysClk);
		alignToEdge();
		arValid = 1'b0;
		rReady  = (stall == 0);		// Zero stall takes the data on its first cycle
		@(negedge iSysClk);
		checkFlag("rValid", rValid, 1'b0);
		@(negedge iSysClk);
		checkFlag("rValid", rValid, 1'b1);		// Two cycles after the handshake
		if (stall > 0)
		begin
			repeat (stall - 1)
				@(posedge iSysClk);
			alignToEdge();
			rReady = 1'b1;
		end
		alignToEdge();
		rReady = 1'b0;
	endtask

	task automatic readAll();
		for (int w = 0; w < RegWords; w++)
			axiRead(addrOf(w));
	endtask

	//--------------------------------------------------------------------
	// LED measurements
	//--------------------------------------------------------------------
	task automatic checkBlink(input int d);
		logic last;
		int   gap;
		int   edges;
		gap   = 0;
		edges = 0;
		@(negedge iSysClk);
		last = ledOut[0];
		while (edges < 5)
		begin
			@(negedge iSysClk);
			gap++;
			if (ledOut[0] != last)
			begin
				if (edges > 0)
					checkCount("blink edge spacing", gap, d + 1);
				edges++;
				gap  = 0;
				last = ledOut[0];
			end
		end
		for (int i = 1; i < LedCount; i++)
			checkLed(i, ledOut[i], 1'b0);
		alignToEdge();
	endtask

	task automatic checkPwm(input ledPkg::ledModeE mode, input int duty, input logic phase);
		int highs;
		axiWrite(addrOf(2), 32'(duty));
		repeat (2)
			@(posedge iSysClk);		// Duty reaches the pin register
		highs = 0;
		repeat (PwmPeriod)
		begin
			@(negedge iSysClk);
			if (ledOut[0])
				highs++;
		end
		checkCount("PWM high cycles", highs, expectHighs(mode, duty, phase));
		alignToEdge();
	endtask

	//--------------------------------------------------------------------
	// Back-pressure, a second request waits behind a held response
	//--------------------------------------------------------------------
	task automatic stallWrites();
		ledPkg::axiRespT held;
		pushWrite(addrOf(6), 32'h15);
		pushWrite(addrOf(11), 32'h2a);
		awAddr  = addrOf(6);
		wData   = 32'h15;
		awValid = 1'b1;
		wValid  = 1'b1;
		@(negedge iSysClk);
		checkFlag("awReady", awReady, 1'b1);
		checkFlag("wReady", wReady, 1'b1);
		alignToEdge();
		awAddr = addrOf(11);
		wData  = 32'h2a;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge iSysClk);
			checkFlag("bValid", bValid, 1'b1);
			checkFlag("awReady", awReady, 1'b0);
			checkFlag("wReady", wReady, 1'b0);
			if (i == 0)
				held = bResp;
			else
				checkResp("bResp", bResp, held);
		end
		alignToEdge();
		bReady = 1'b1;
		alignToEdge();		// First response taken
		@(negedge iSysClk);
		checkFlag("bValid", bValid, 1'b0);
		checkFlag("awReady", awReady, 1'b1);
		checkFlag("wReady", wReady, 1'b1);
		alignToEdge();
		awValid = 1'b0;
		wValid  = 1'b0;
		@(negedge iSysClk);
		checkFlag("bValid", bValid, 1'b1);
		alignToEdge();
		bReady = 1'b0;
	endtask

	task automatic stallReads();
		ledPkg::axiDataT held;
		ledPkg::axiRespT heldResp;
		pushRead(addrOf(6));
		pushRead(addrOf(11));
		arAddr  = addrOf(6);
		arValid = 1'b1;
		@(negedge iSysClk);
		checkFlag("arReady", arReady, 1'b1);
		alignToEdge();
		arAddr = addrOf(11);
		@(negedge iSysClk);
		checkFlag("rValid", rValid, 1'b0);
		checkFlag("arReady", arReady, 1'b0);
		for (int i = 0; i < 5; i++)
		begin
			@(negedge iSysClk);
			checkFlag("rValid", rValid, 1'b1);
			checkFlag("arReady", arReady, 1'b0);
			if (i == 0)
			begin
				held     = rData;
				heldResp = rResp;
			end
			else
			begin
				checkData("rData", rData, held);
				checkResp("rResp", rResp, heldResp);
			end
		end
		alignToEdge();
		rReady = 1'b1;
		alignToEdge();
		@(negedge iSysClk);
		checkFlag("arReady", arReady, 1'b1);
		alignToEdge();
		arValid = 1'b0;
		@(negedge iSysClk);
		checkFlag("rValid", rValid, 1'b0);
		@(negedge iSysClk);
		checkFlag("rValid", rValid, 1'b1);		// Latency still two cycles
		alignToEdge();
		rReady = 1'b0;
	endtask

	//--------------------------------------------------------------------
	// Test sequence
	//--------------------------------------------------------------------
	initial
	begin
		ledPkg::axiAddrT badAddr [4];
		badAddr[0] = {BlockId, 8'h30};		// Past the last divisor
		badAddr[1] = {BlockId, 8'h06};		// Misaligned
		badAddr[2] = {8'h02, 8'h00};		// Foreign block
		badAddr[3] = {BlockId, 8'hfc};
		awAddr  = '0;
		awValid = 1'b0;
		wData   = '0;
		wValid  = 1'b0;
		bReady  = 1'b0;
		arAddr  = '0;
		arValid = 1'b0;
		rReady  = 1'b0;
		reset   = 1'b1;
		shEn    = '0;
		shMode  = 2'(ledPkg::ModeSteady);
		for (int i = 0; i < LedCount; i++)
		begin
			shDuty[i] = '0;
			shDiv[i]  = '1;
		end
		repeat (5)
			@(posedge iSysClk);
		#1;
		reset = 1'b0;
		@(negedge iSysClk);
		checkFlag("awReady", awReady, 1'b0);
		checkFlag("wReady", wReady, 1'b0);
		checkFlag("arReady", arReady, 1'b0);
		checkFlag("bValid", bValid, 1'b0);
		checkFlag("rValid", rValid, 1'b0);
		alignToEdge();

		readAll();		// Reset values
		for (int i = 0; i < LedCount; i++)
			checkLed(i, ledOut[i], 1'b0);

		for (int w = 0; w < RegWords; w++)
			axiWrite(addrOf(w), $random(seed));
		readAll();

		for (int i = 0; i < 4; i++)
		begin
			axiWrite(badAddr[i], 32'hffff_ffff);
			axiRead(badAddr[i]);
		end
		readAll();

		// Steady, then blink on LED 0 alone
		axiWrite(addrOf(1), 32'(ledPkg::ModeSteady));
		axiWrite(addrOf(0), 32'h05);
		repeat (3)
			@(negedge iSysClk);
		for (int i = 0; i < LedCount; i++)
			checkLed(i, ledOut[i], expectLed(ledPkg::ModeSteady, 0, 0, 1'b0, shEn[i]));
		alignToEdge();
		axiWrite(addrOf(0), 32'h00);
		axiWrite(addrOf(2 + LedCount), 32'd9);
		axiWrite(addrOf(1), 32'(ledPkg::ModeBlink));
		axiWrite(addrOf(0), 32'h01);
		checkBlink(9);

		axiWrite(addrOf(1), 32'(ledPkg::ModePwm));
		checkPwm(ledPkg::ModePwm, 0, 1'b1);
		checkPwm(ledPkg::ModePwm, 20, 1'b1);
		checkPwm(ledPkg::ModePwm, 63, 1'b1);

		// Re-enable holds the phase low for divisor+1 cycles
		axiWrite(addrOf(0), 32'h00);
		axiWrite(addrOf(2 + LedCount), 32'd200);
		axiWrite(addrOf(1), 32'(ledPkg::ModePwmBlink));
		axiWrite(addrOf(0), 32'h01);
		checkPwm(ledPkg::ModePwmBlink, 63, 1'b0);

		stallWrites();
		stallReads();
		repeat (2)
			@(posedge iSysClk);

		if (rdExpData.size() != 0 || wrExpResp.size() != 0)
		begin
			$display("some bus responses never arrived");
			stopRun();
		end
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule
